// ==== common/bus_pkg.sv ====
// Bus widths and opcode encoding shared by the
// request and response channels of the transaction mux

package bus_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channel widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // Upstream transaction ID, restored on the way back
  localparam int unsigned UpIdWidth = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [0:0] {
    op_read  = 1'b0,
    op_write = 1'b1
  } op_e;

endpackage

// ==== common/remap_pkg.sv ====
// Slot state and record type of the ID remap table

package remap_pkg;

  import bus_pkg::*;

  typedef enum logic {
    slot_free = 1'b0,
    slot_busy = 1'b1
  } slot_state_e;

  // Origin of an outstanding transaction
  // Port field covers up to 256 upstream ports
  typedef struct packed {
    logic [7:0]           port;
    logic [UpIdWidth-1:0] id;
  } slot_rec_t;

endpackage

// ==== common/txn_if.sv ====
// Request and response channel interfaces used between the mux blocks
`timescale 1ns/1ps

interface req_if import bus_pkg::*; #(
  parameter int unsigned NumPorts = 4
);

  localparam int unsigned PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                 valid;
  logic                 ready;
  logic [PortWidth-1:0] port;
  logic [UpIdWidth-1:0] id;
  logic [AddrWidth-1:0] addr;
  logic [DataWidth-1:0] data;
  op_e                  op;

  modport src (output valid, port, id, addr, data, op, input ready);
  modport dst (input valid, port, id, addr, data, op, output ready);

endinterface

// Response back towards the upstream side, tagged with the origin port
interface rsp_if import bus_pkg::*; #(
  parameter int unsigned NumPorts = 4
);

  localparam int unsigned PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                 valid;
  logic                 ready;
  logic [PortWidth-1:0] port;
  logic [UpIdWidth-1:0] id;
  logic [DataWidth-1:0] data;

  modport src (output valid, port, id, data, input ready);
  modport dst (input valid, port, id, data, output ready);

endinterface

// ==== mux/port_arbiter.sv ====
// Round-robin arbiter over the upstream request ports
`timescale 1ns/1ps

module port_arbiter import bus_pkg::*; #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  input  logic [NumPorts-1:0]                 up_req_valid_i,
  output logic [NumPorts-1:0]                 up_req_ready_o,
  input  logic [NumPorts-1:0][UpIdWidth-1:0]  up_req_id_i,
  input  logic [NumPorts-1:0][AddrWidth-1:0]  up_req_addr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]  up_req_data_i,
  input  op_e  [NumPorts-1:0]                 up_req_op_i,
  req_if.src                                  req_o
);

  localparam int unsigned PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic [PortWidth-1:0] rr_ptr_q;
  logic [PortWidth-1:0] grant_idx;
  logic                 grant_valid;
  logic                 xfer;

  ////////////////////////////////////////////////////////////////////////////
  // Grant selection
  ////////////////////////////////////////////////////////////////////////////

  // First valid port at or after the pointer, wrapping around
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = '0;
    for (int unsigned i = 0; i < NumPorts; i++) begin
      idx = rr_ptr_q + i;
      if (idx >= NumPorts) begin
        idx = idx - NumPorts;
      end
      if (!grant_valid && up_req_valid_i[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = PortWidth'(idx);
      end
    end
  end

  assign req_o.valid = grant_valid;
  assign req_o.port  = grant_idx;
  assign req_o.id    = up_req_id_i[grant_idx];
  assign req_o.addr  = up_req_addr_i[grant_idx];
  assign req_o.data  = up_req_data_i[grant_idx];
  assign req_o.op    = up_req_op_i[grant_idx];

  // Ready goes back to the granted port only
  always_comb begin
    up_req_ready_o            = '0;
    up_req_ready_o[grant_idx] = grant_valid & req_o.ready;
  end

  assign xfer = req_o.valid & req_o.ready;

  ////////////////////////////////////////////////////////////////////////////
  // Round-robin pointer
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_ptr_q <= '0;
    end else if (xfer) begin
      if (int'(grant_idx) == NumPorts - 1) begin
        rr_ptr_q <= '0;
      end else begin
        rr_ptr_q <= grant_idx + 1'b1;
      end
    end
  end

  // Never more than one port sees its request taken
  assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(up_req_ready_o))
    else $error("port_arbiter: more than one upstream ready");

endmodule

// ==== remap/id_remap_table.sv ====
// ID remap table: slot allocation, downstream request register
// and restoration of origin port and ID on responses
`timescale 1ns/1ps

module id_remap_table import bus_pkg::*; import remap_pkg::*; #(
  parameter  int unsigned NumPorts  = 4,
  parameter  int unsigned MaxTxns   = 4,
  localparam int unsigned DnIdWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n_i,
  // Downstream request
  output logic                 dn_req_valid_o,
  input  logic                 dn_req_ready_i,
  output logic [DnIdWidth-1:0] dn_req_id_o,
  output logic [AddrWidth-1:0] dn_req_addr_o,
  output logic [DataWidth-1:0] dn_req_data_o,
  output op_e                  dn_req_op_o,
  // Downstream response
  input  logic                 dn_rsp_valid_i,
  output logic                 dn_rsp_ready_o,
  input  logic [DnIdWidth-1:0] dn_rsp_id_i,
  input  logic [DataWidth-1:0] dn_rsp_data_i,
  req_if.dst                   req_i,
  rsp_if.src                   rsp_o
);

  localparam int unsigned PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  slot_state_e          slot_state_q [MaxTxns];
  slot_rec_t            slot_rec_q   [MaxTxns];
  slot_rec_t            rsp_rec;
  logic                 any_free;
  logic [DnIdWidth-1:0] free_idx;
  logic                 req_accept;
  logic                 rsp_done;

  logic                 dn_req_valid_q;
  logic [DnIdWidth-1:0] dn_req_id_q;
  logic [AddrWidth-1:0] dn_req_addr_q;
  logic [DataWidth-1:0] dn_req_data_q;
  op_e                  dn_req_op_q;

  ////////////////////////////////////////////////////////////////////////////
  // Slot allocation
  ////////////////////////////////////////////////////////////////////////////

  // Lowest free slot wins, hence the downward scan
  always_comb begin
    any_free = 1'b0;
    free_idx = '0;
    for (int i = MaxTxns - 1; i >= 0; i--) begin
      if (slot_state_q[i] == slot_free) begin
        any_free = 1'b1;
        free_idx = DnIdWidth'(i);
      end
    end
  end

  assign req_i.ready = any_free & (~dn_req_valid_q | dn_req_ready_i);
  assign req_accept  = req_i.valid & req_i.ready;
  assign rsp_done    = dn_rsp_valid_i & rsp_o.ready;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MaxTxns; i++) begin
        slot_state_q[i] <= slot_free;
      end
    end else begin
      for (int i = 0; i < MaxTxns; i++) begin
        if (rsp_done && dn_rsp_id_i == DnIdWidth'(i)) begin
          slot_state_q[i] <= slot_free;
        end
        if (req_accept && free_idx == DnIdWidth'(i)) begin
          slot_state_q[i] <= slot_busy;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      slot_rec_q[free_idx].port <= 8'(req_i.port);
      slot_rec_q[free_idx].id   <= req_i.id;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Downstream request register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dn_req_valid_q <= 1'b0;
    end else if (req_accept) begin
      dn_req_valid_q <= 1'b1;
    end else if (dn_req_ready_i) begin
      dn_req_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_accept) begin
      dn_req_id_q   <= free_idx;
      dn_req_addr_q <= req_i.addr;
      dn_req_data_q <= req_i.data;
      dn_req_op_q   <= req_i.op;
    end
  end

  assign dn_req_valid_o = dn_req_valid_q;
  assign dn_req_id_o    = dn_req_id_q;
  assign dn_req_addr_o  = dn_req_addr_q;
  assign dn_req_data_o  = dn_req_data_q;
  assign dn_req_op_o    = dn_req_op_q;

  // Response lookup, original port and ID go back with the data
  assign rsp_rec        = slot_rec_q[dn_rsp_id_i];
  assign rsp_o.valid    = dn_rsp_valid_i;
  assign rsp_o.port     = rsp_rec.port[PortWidth-1:0];
  assign rsp_o.id       = rsp_rec.id;
  assign rsp_o.data     = dn_rsp_data_i;
  assign dn_rsp_ready_o = rsp_o.ready;

  assert property (@(posedge clk) disable iff (!rst_n_i)
    dn_rsp_valid_i |-> slot_state_q[dn_rsp_id_i] == slot_busy)
    else $error("id_remap_table: response for a free slot");

  assert property (@(posedge clk) disable iff (!rst_n_i)
    dn_req_valid_o && !dn_req_ready_i |=> dn_req_valid_o &&
      $stable({dn_req_id_o, dn_req_addr_o, dn_req_data_o, dn_req_op_o}))
    else $error("id_remap_table: request changed under back-pressure");

endmodule

// ==== mux/rsp_router.sv ====
// One-entry response register steering responses to their origin port
`timescale 1ns/1ps

module rsp_router import bus_pkg::*; #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  output logic [NumPorts-1:0]                 up_rsp_valid_o,
  input  logic [NumPorts-1:0]                 up_rsp_ready_i,
  output logic [NumPorts-1:0][UpIdWidth-1:0]  up_rsp_id_o,
  output logic [NumPorts-1:0][DataWidth-1:0]  up_rsp_data_o,
  rsp_if.dst                                  rsp_i
);

  localparam int unsigned PortWidth = (NumPorts > 1) ? $clog2(NumPorts) : 1;

  logic                 rsp_valid_q;
  logic [PortWidth-1:0] rsp_port_q;
  logic [UpIdWidth-1:0] rsp_id_q;
  logic [DataWidth-1:0] rsp_data_q;
  logic                 taken;

  assign taken       = rsp_valid_q & up_rsp_ready_i[rsp_port_q];
  assign rsp_i.ready = ~rsp_valid_q | taken;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (rsp_i.ready) begin
      rsp_valid_q <= rsp_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rsp_i.valid && rsp_i.ready) begin
      rsp_port_q <= rsp_i.port;
      rsp_id_q   <= rsp_i.id;
      rsp_data_q <= rsp_i.data;
    end
  end

  // Only the origin port sees valid
  always_comb begin
    for (int p = 0; p < NumPorts; p++) begin
      up_rsp_valid_o[p] = rsp_valid_q && (rsp_port_q == PortWidth'(p));
      up_rsp_id_o[p]    = rsp_id_q;
      up_rsp_data_o[p]  = rsp_data_q;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    $onehot0(up_rsp_valid_o))
    else $error("rsp_router: more than one upstream response valid");

endmodule

// ==== hdl/txn_mux_top.sv ====
// Transaction mux top level: arbiter, ID remap table and response router
`timescale 1ns/1ps

module txn_mux_top import bus_pkg::*; #(
  parameter  int unsigned NumPorts  = 4,
  parameter  int unsigned MaxTxns   = 4,
  localparam int unsigned DnIdWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1
) (
  input  logic                                clk,
  input  logic                                rst_n_i,
  // Upstream requests
  input  logic [NumPorts-1:0]                 up_req_valid_i,
  output logic [NumPorts-1:0]                 up_req_ready_o,
  input  logic [NumPorts-1:0][UpIdWidth-1:0]  up_req_id_i,
  input  logic [NumPorts-1:0][AddrWidth-1:0]  up_req_addr_i,
  input  logic [NumPorts-1:0][DataWidth-1:0]  up_req_data_i,
  input  op_e  [NumPorts-1:0]                 up_req_op_i,
  // Upstream responses
  output logic [NumPorts-1:0]                 up_rsp_valid_o,
  input  logic [NumPorts-1:0]                 up_rsp_ready_i,
  output logic [NumPorts-1:0][UpIdWidth-1:0]  up_rsp_id_o,
  output logic [NumPorts-1:0][DataWidth-1:0]  up_rsp_data_o,
  // Downstream request
  output logic                                dn_req_valid_o,
  input  logic                                dn_req_ready_i,
  output logic [DnIdWidth-1:0]                dn_req_id_o,
  output logic [AddrWidth-1:0]                dn_req_addr_o,
  output logic [DataWidth-1:0]                dn_req_data_o,
  output op_e                                 dn_req_op_o,
  // Downstream response
  input  logic                                dn_rsp_valid_i,
  output logic                                dn_rsp_ready_o,
  input  logic [DnIdWidth-1:0]                dn_rsp_id_i,
  input  logic [DataWidth-1:0]                dn_rsp_data_i
);

  req_if #(.NumPorts(NumPorts)) req_bus ();
  rsp_if #(.NumPorts(NumPorts)) rsp_bus ();

  port_arbiter #(
    .NumPorts ( NumPorts )
  ) port_arbiter_i (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .up_req_valid_i ( up_req_valid_i ),
    .up_req_ready_o ( up_req_ready_o ),
    .up_req_id_i    ( up_req_id_i    ),
    .up_req_addr_i  ( up_req_addr_i  ),
    .up_req_data_i  ( up_req_data_i  ),
    .up_req_op_i    ( up_req_op_i    ),
    .req_o          ( req_bus.src    )
  );

  id_remap_table #(
    .NumPorts ( NumPorts ),
    .MaxTxns  ( MaxTxns  )
  ) id_remap_table_i (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .dn_req_valid_o ( dn_req_valid_o ),
    .dn_req_ready_i ( dn_req_ready_i ),
    .dn_req_id_o    ( dn_req_id_o    ),
    .dn_req_addr_o  ( dn_req_addr_o  ),
    .dn_req_data_o  ( dn_req_data_o  ),
    .dn_req_op_o    ( dn_req_op_o    ),
    .dn_rsp_valid_i ( dn_rsp_valid_i ),
    .dn_rsp_ready_o ( dn_rsp_ready_o ),
    .dn_rsp_id_i    ( dn_rsp_id_i    ),
    .dn_rsp_data_i  ( dn_rsp_data_i  ),
    .req_i          ( req_bus.dst    ),
    .rsp_o          ( rsp_bus.src    )
  );

  rsp_router #(
    .NumPorts ( NumPorts )
  ) rsp_router_i (
    .clk            ( clk            ),
    .rst_n_i        ( rst_n_i        ),
    .up_rsp_valid_o ( up_rsp_valid_o ),
    .up_rsp_ready_i ( up_rsp_ready_i ),
    .up_rsp_id_o    ( up_rsp_id_o    ),
    .up_rsp_data_o  ( up_rsp_data_o  ),
    .rsp_i          ( rsp_bus.dst    )
  );

endmodule

// ==== test/txn_mux_model.svh ====
// Reference model of the transaction mux: slot table, round-robin pointer,
// expected downstream request and expected upstream response
`ifndef TXN_MUX_MODEL_SVH
`define TXN_MUX_MODEL_SVH

logic                 m_busy [MaxTxns];
int                   m_port [MaxTxns];
logic [UpIdWidth-1:0] m_id   [MaxTxns];
logic [AddrWidth-1:0] m_addr [MaxTxns];
int                   m_rr_ptr;

// Request held in the downstream register
logic                 m_dn_valid;
logic [DnIdWidth-1:0] m_dn_id;
logic [AddrWidth-1:0] m_dn_addr;
logic [DataWidth-1:0] m_dn_data;
op_e                  m_dn_op;

// Response held in the router
logic                 m_up_valid;
int                   m_up_port;
logic [UpIdWidth-1:0] m_up_id;
logic [DataWidth-1:0] m_up_data;

task automatic model_reset();
  for (int i = 0; i < MaxTxns; i++) begin
    m_busy[i] = 1'b0;
  end
  m_rr_ptr   = 0;
  m_dn_valid = 1'b0;
  m_up_valid = 1'b0;
endtask

function automatic int lowest_free_slot();
  for (int i = 0; i < MaxTxns; i++) begin
    if (!m_busy[i]) return i;
  end
  return -1;
endfunction

// First requesting port at or after the pointer
function automatic int next_grant(input logic [NumPorts-1:0] valid);
  int p;
  for (int i = 0; i < NumPorts; i++) begin
    p = (m_rr_ptr + i) % NumPorts;
    if (valid[p]) return p;
  end
  return -1;
endfunction

// Responder data is a fixed scramble of the request address
function automatic logic [DataWidth-1:0] rsp_data_for(input logic [AddrWidth-1:0] addr);
  return {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
endfunction

`endif

// ==== test/txn_mux_tb.sv ====
// Testbench for the transaction mux with random traffic checked against a reference model
`timescale 1ns/1ps

module txn_mux_tb import bus_pkg::*; ();

  localparam int NumPorts      = 4;
  localparam int MaxTxns       = 4;
  localparam int DnIdWidth     = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int TotalTxns     = 120 + 40 + (MaxTxns + 8) + 120;
  localparam int TimeoutCycles = TotalTxns * 200 + 2000;

  logic clk;
  logic rst_n;
  logic [NumPorts-1:0]                up_req_valid;
  logic [NumPorts-1:0]                up_req_ready;
  logic [NumPorts-1:0][UpIdWidth-1:0] up_req_id;
  logic [NumPorts-1:0][AddrWidth-1:0] up_req_addr;
  logic [NumPorts-1:0][DataWidth-1:0] up_req_data;
  op_e  [NumPorts-1:0]                up_req_op;
  logic [NumPorts-1:0]                up_rsp_valid;
  logic [NumPorts-1:0]                up_rsp_ready;
  logic [NumPorts-1:0][UpIdWidth-1:0] up_rsp_id;
  logic [NumPorts-1:0][DataWidth-1:0] up_rsp_data;
  logic                 dn_req_valid;
  logic                 dn_req_ready;
  logic [DnIdWidth-1:0] dn_req_id;
  logic [AddrWidth-1:0] dn_req_addr;
  logic [DataWidth-1:0] dn_req_data;
  op_e                  dn_req_op;
  logic                 dn_rsp_valid;
  logic                 dn_rsp_ready;
  logic [DnIdWidth-1:0] dn_rsp_id;
  logic [DataWidth-1:0] dn_rsp_data;

  integer seed = 32'h2c81;
  int req_pct, dn_ready_pct, rsp_pct, up_ready_pct;
  int issued = 0;
  int issue_limit = 0;
  int err_cnt = 0;
  int test_cnt = 0;
  int test_fail_cnt = 0;
  int dn_hs_cnt = 0;
  int up_hs_cnt = 0;
  int rsp_hs_cnt = 0;
  int done_cnt = 0;
  logic [NumPorts-1:0] up_acc = '0;
  logic                rsp_acc = 1'b0;
  int                   rsp_q_id[$];
  logic [AddrWidth-1:0] rsp_q_addr[$];

  `include "txn_mux_model.svh"

  txn_mux_top #(.NumPorts(NumPorts), .MaxTxns(MaxTxns)) txn_mux_top_i (
    .clk(clk), .rst_n_i(rst_n),
    .up_req_valid_i(up_req_valid), .up_req_ready_o(up_req_ready),
    .up_req_id_i(up_req_id), .up_req_addr_i(up_req_addr),
    .up_req_data_i(up_req_data), .up_req_op_i(up_req_op),
    .up_rsp_valid_o(up_rsp_valid), .up_rsp_ready_i(up_rsp_ready),
    .up_rsp_id_o(up_rsp_id), .up_rsp_data_o(up_rsp_data),
    .dn_req_valid_o(dn_req_valid), .dn_req_ready_i(dn_req_ready),
    .dn_req_id_o(dn_req_id), .dn_req_addr_o(dn_req_addr),
    .dn_req_data_o(dn_req_data), .dn_req_op_o(dn_req_op),
    .dn_rsp_valid_i(dn_rsp_valid), .dn_rsp_ready_o(dn_rsp_ready),
    .dn_rsp_id_i(dn_rsp_id), .dn_rsp_data_i(dn_rsp_data)
  );

  function automatic int roll_below(input int n);
    int unsigned r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  task automatic note_fail(input string msg);
    $display("FAIL %0t: %s", $time, msg);
    err_cnt++;
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Upstream requesters, ready sources and downstream responder
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] r;
    int k;
    up_req_valid = '0;
    up_req_id    = '0;
    up_req_addr  = '0;
    up_req_data  = '0;
    for (int p = 0; p < NumPorts; p++) begin
      up_req_op[p] = op_read;
    end
    up_rsp_ready = '0;
    dn_req_ready = 1'b0;
    dn_rsp_valid = 1'b0;
    dn_rsp_id    = '0;
    dn_rsp_data  = '0;
    forever begin
      @(posedge clk);
      for (int p = 0; p < NumPorts; p++) begin
        if (!up_req_valid[p] || up_acc[p]) begin
          if (issued < issue_limit && roll_below(100) < req_pct) begin
            r = $random(seed);
            up_req_valid[p] <= 1'b1;
            up_req_id[p]    <= UpIdWidth'(r);
            up_req_op[p]    <= r[31] ? op_write : op_read;
            up_req_addr[p]  <= $random(seed);
            up_req_data[p]  <= $random(seed);
            issued++;
          end else begin
            up_req_valid[p] <= 1'b0;
          end
        end
        up_rsp_ready[p] <= roll_below(100) < up_ready_pct;
      end
      dn_req_ready <= roll_below(100) < dn_ready_pct;
      // Answers outstanding requests in random order
      if (!dn_rsp_valid || rsp_acc) begin
        if (rsp_q_id.size() > 0 && roll_below(100) < rsp_pct) begin
          k = roll_below(rsp_q_id.size());
          dn_rsp_valid <= 1'b1;
          dn_rsp_id    <= DnIdWidth'(rsp_q_id[k]);
          dn_rsp_data  <= rsp_data_for(rsp_q_addr[k]);
          rsp_q_id.delete(k);
          rsp_q_addr.delete(k);
        end else begin
          dn_rsp_valid <= 1'b0;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Monitor comparing DUT ports with the model and applying handshakes
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    int g;
    int s;
    int p;
    logic [NumPorts-1:0] exp_ready;
    logic [NumPorts-1:0] exp_up;
    if (!rst_n) begin
      model_reset();
      up_acc  = '0;
      rsp_acc = 1'b0;
    end else begin
      g = next_grant(up_req_valid);
      exp_ready = '0;
      if (g >= 0 && lowest_free_slot() >= 0 && (!m_dn_valid || dn_req_ready)) begin
        exp_ready[g] = 1'b1;
      end
      if (up_req_ready !== exp_ready) begin
        note_fail($sformatf("upstream ready %b, expected %b", up_req_ready, exp_ready));
      end
      if (dn_req_valid !== m_dn_valid) begin
        note_fail($sformatf("downstream valid %b, expected %b", dn_req_valid, m_dn_valid));
      end else if (m_dn_valid && {dn_req_id, dn_req_addr, dn_req_data, dn_req_op} !==
                   {m_dn_id, m_dn_addr, m_dn_data, m_dn_op}) begin
        note_fail($sformatf("downstream request id %0h addr %h, expected id %0h addr %h",
                            dn_req_id, dn_req_addr, m_dn_id, m_dn_addr));
      end
      exp_up = '0;
      if (m_up_valid) begin
        exp_up[m_up_port] = 1'b1;
      end
      if (up_rsp_valid !== exp_up) begin
        note_fail($sformatf("upstream response valid %b, expected %b", up_rsp_valid, exp_up));
      end else if (m_up_valid && {up_rsp_id[m_up_port], up_rsp_data[m_up_port]} !==
                   {m_up_id, m_up_data}) begin
        note_fail($sformatf("port %0d response id %0h data %h, expected id %0h data %h",
                            m_up_port, up_rsp_id[m_up_port], up_rsp_data[m_up_port],
                            m_up_id, m_up_data));
      end
      if (dn_rsp_ready !== (!m_up_valid || up_rsp_ready[m_up_port])) begin
        note_fail($sformatf("downstream response ready %b is wrong", dn_rsp_ready));
      end

      // Handshakes taking place at the coming rising edge
      up_acc  = up_req_valid & up_req_ready;
      rsp_acc = dn_rsp_valid & dn_rsp_ready;
      if ((up_rsp_valid & up_rsp_ready) != '0) begin
        m_up_valid = 1'b0;
        done_cnt++;
      end
      if (dn_req_valid && dn_req_ready) begin
        rsp_q_id.push_back(int'(dn_req_id));
        rsp_q_addr.push_back(dn_req_addr);
        m_dn_valid = 1'b0;
        dn_hs_cnt++;
      end
      if (up_acc != '0) begin
        p = 0;
        while (!up_acc[p]) begin
          p++;
        end
        s = lowest_free_slot();
        if (s < 0) begin
          note_fail("a request was accepted while the table was full");
        end else begin
          m_busy[s]  = 1'b1;
          m_port[s]  = p;
          m_id[s]    = up_req_id[p];
          m_addr[s]  = up_req_addr[p];
          m_dn_valid = 1'b1;
          m_dn_id    = DnIdWidth'(s);
          m_dn_addr  = up_req_addr[p];
          m_dn_data  = up_req_data[p];
          m_dn_op    = up_req_op[p];
        end
        m_rr_ptr = (p + 1) % NumPorts;
        up_hs_cnt++;
      end
      if (rsp_acc) begin
        s = int'(dn_rsp_id);
        if (!m_busy[s]) begin
          note_fail("a response arrived for a slot the model holds free");
        end else begin
          m_up_valid = 1'b1;
          m_up_port  = m_port[s];
          m_up_id    = m_id[s];
          m_up_data  = rsp_data_for(m_addr[s]);
          m_busy[s]  = 1'b0;
        end
        rsp_hs_cnt++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic finish_test(input string name, input int start_err);
    test_cnt++;
    if (err_cnt == start_err) begin
      $display("Test %s: ok", name);
    end else begin
      $display("Test %s: failed with %0d errors", name, err_cnt - start_err);
      test_fail_cnt++;
    end
  endtask

  task automatic run_traffic(input string name, input int count, input int req_p,
                             input int dn_p, input int rsp_p, input int up_p);
    int start_err;
    int target;
    start_err    = err_cnt;
    target       = done_cnt + count;
    req_pct      = req_p;
    dn_ready_pct = dn_p;
    rsp_pct      = rsp_p;
    up_ready_pct = up_p;
    issue_limit  = issued + count;
    while (done_cnt < target) @(negedge clk);
    finish_test(name, start_err);
  endtask

  initial begin
    int start_err;
    int base_dn;
    int base_up;
    int base_rsp;
    int target;
    rst_n        = 1'b0;
    req_pct      = 0;
    dn_ready_pct = 0;
    rsp_pct      = 0;
    up_ready_pct = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    start_err = err_cnt;
    if (dn_req_valid !== 1'b0 || up_rsp_valid !== '0) begin
      note_fail("valid outputs are not low after reset");
    end
    finish_test("reset", start_err);

    run_traffic("forwarding and response return", 120, 60, 100, 70, 100);
    run_traffic("round-robin order", 40, 100, 100, 100, 100);

    // Responses withheld until the table has filled up
    start_err    = err_cnt;
    base_dn      = dn_hs_cnt;
    base_up      = up_hs_cnt;
    target       = done_cnt + MaxTxns + 8;
    req_pct      = 100;
    rsp_pct      = 0;
    issue_limit  = issued + MaxTxns + 8;
    while (dn_hs_cnt - base_dn < MaxTxns) @(negedge clk);
    // Table stays full while no response comes back
    repeat (MaxTxns * 2 + 10) @(negedge clk);
    if (dn_hs_cnt - base_dn != MaxTxns || up_hs_cnt - base_up != MaxTxns) begin
      note_fail($sformatf("%0d requests left downstream with the table full, expected %0d",
                          dn_hs_cnt - base_dn, MaxTxns));
    end
    base_rsp = rsp_hs_cnt;
    base_up  = up_hs_cnt;
    rsp_pct  = 100;
    while (rsp_hs_cnt == base_rsp) @(negedge clk);
    repeat (3) @(negedge clk);
    if (up_hs_cnt == base_up) begin
      note_fail("no request was accepted after a slot was freed");
    end
    while (done_cnt < target) @(negedge clk);
    finish_test("table full", start_err);

    run_traffic("back-pressure", 120, 70, 50, 60, 40);

    $display("Tests run: %0d, failed: %0d, check errors: %0d",
             test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== txn_mux_top.f ====
+incdir+test
common/bus_pkg.sv
common/remap_pkg.sv
common/txn_if.sv
mux/port_arbiter.sv
remap/id_remap_table.sv
mux/rsp_router.sv
hdl/txn_mux_top.sv
test/txn_mux_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert
TOP       := txn_mux_tb
FILELIST  := txn_mux_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := All tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
